/* kf_consts.svh */
// Kalman tracker constants
// Fixed-point word layout, filter dimensions and the fixed coefficient words.
// Words are sign-magnitude with 1 sign, 16 integer and 15 fraction bits.

`ifndef KF_CONSTS_SVH
`define KF_CONSTS_SVH

// Word layout
`define KF_W 32
`define KF_F 15
`define KF_I 16

// State and measurement counts
`define KF_NS 4
`define KF_NM 2

// Width of the position and measurement ports
`define KF_DISP_W 11

// Coefficients: 1.0, time step of 2^-5, measurement noise of 1000.0
`define KF_ONE   32'h0000_8000
`define KF_TSTEP 32'h0000_0400
`define KF_RDIAG 32'h01F4_0000

`endif

/* kf_pkg.sv */
// Kalman tracker package
// Sign-magnitude fixed-point word type and its add, subtract and multiply.

`include "kf_consts.svh"

package kf_pkg;

	// One word seen either raw or split into its fields
	typedef union packed {
		logic [`KF_W-1:0] raw;
		struct packed {
			logic              sign;
			logic [`KF_I-1:0]  int_part;
			logic [`KF_F-1:0]  frac;
		} f;
	} kf_fix_t;

	// Equal signs add magnitudes, otherwise the larger magnitude wins the sign
	function automatic kf_fix_t fix_add(input kf_fix_t a, input kf_fix_t b);
		kf_fix_t          res;
		logic [`KF_W-2:0] mag_a;
		logic [`KF_W-2:0] mag_b;
		mag_a = {a.f.int_part, a.f.frac};
		mag_b = {b.f.int_part, b.f.frac};
		if (a.f.sign == b.f.sign) begin
			res.raw = {a.f.sign, mag_a + mag_b};
		end else if (mag_a >= mag_b) begin
			res.raw = {a.f.sign, mag_a - mag_b};
		end else begin
			res.raw = {b.f.sign, mag_b - mag_a};
		end
		// No negative zero
		if (res.raw[`KF_W-2:0] == '0) begin
			res.f.sign = 1'b0;
		end
		return res;
	endfunction

	function automatic kf_fix_t fix_sub(input kf_fix_t a, input kf_fix_t b);
		kf_fix_t nb;
		nb = b;
		nb.f.sign = ~b.f.sign;
		return fix_add(a, nb);
	endfunction

	// Full magnitude product, keep the 31 bits just above the fraction
	function automatic kf_fix_t fix_mul(input kf_fix_t a, input kf_fix_t b);
		kf_fix_t                  res;
		logic [`KF_W-2:0]         mag_a;
		logic [`KF_W-2:0]         mag_b;
		logic [2*(`KF_W-1)-1:0]   prod;
		mag_a = {a.f.int_part, a.f.frac};
		mag_b = {b.f.int_part, b.f.frac};
		prod = mag_a * mag_b;
		res.raw = {a.f.sign ^ b.f.sign, prod[`KF_F+`KF_W-2:`KF_F]};
		return res;
	endfunction

endpackage

/* kf_step_if.sv */
// Kalman step strobes
// One-cycle strobes from the sequencer that clear and load the datapath registers.

`timescale 1ns/1ps

interface kf_step_if;

	logic clear_all;
	logic clear_tmp;
	logic accept;
	logic ld_pred1;
	logic ld_pred2;
	logic ld_innov;
	logic ld_det;
	logic ld_update;

	modport seq (output clear_all, clear_tmp, accept, ld_pred1, ld_pred2,
		ld_innov, ld_det, ld_update);
	modport dp (input clear_all, clear_tmp, accept, ld_pred1, ld_pred2,
		ld_innov, ld_det, ld_update);

endinterface

/* kf_sequencer.sv */
// Kalman sequencer
// Walks one filter iteration per accepted measurement and decodes its state
// into the datapath step strobes and the ready level.

`timescale 1ns/1ps

module kf_sequencer (
	input  logic   clk,
	input  logic   aresetn,
	input  logic   i_valid,
	output logic   o_ready,
	kf_step_if.seq step
);

	localparam logic [2:0] ST_INIT      = 3'd0;
	localparam logic [2:0] ST_IDLE      = 3'd1;
	localparam logic [2:0] ST_PREDICT_1 = 3'd2;
	localparam logic [2:0] ST_PREDICT_2 = 3'd3;
	localparam logic [2:0] ST_INTERIM   = 3'd4;
	localparam logic [2:0] ST_DET       = 3'd5;
	localparam logic [2:0] ST_UPDATE    = 3'd6;

	logic [2:0] state;
	logic [2:0] state_nxt;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= ST_INIT;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		case (state)
			ST_INIT:      state_nxt = ST_IDLE;
			ST_IDLE:      state_nxt = i_valid ? ST_PREDICT_1 : ST_IDLE;
			ST_PREDICT_1: state_nxt = ST_PREDICT_2;
			ST_PREDICT_2: state_nxt = ST_INTERIM;
			ST_INTERIM:   state_nxt = ST_DET;
			ST_DET:       state_nxt = ST_UPDATE;
			ST_UPDATE:    state_nxt = ST_IDLE;
			default:      state_nxt = ST_INIT;
		endcase
	end

	// Strobes follow the state directly
	assign o_ready        = (state == ST_IDLE);
	assign step.clear_all = (state == ST_INIT);
	assign step.clear_tmp = (state == ST_INIT) || (state == ST_IDLE);
	assign step.accept    = (state == ST_IDLE) && i_valid;
	assign step.ld_pred1  = (state == ST_PREDICT_1);
	assign step.ld_pred2  = (state == ST_PREDICT_2);
	assign step.ld_innov  = (state == ST_INTERIM);
	assign step.ld_det    = (state == ST_DET);
	assign step.ld_update = (state == ST_UPDATE);

endmodule

/* kf_state_predict.sv */
// Kalman state prediction
// Holds the current and predicted state vectors and drives the position outputs.

`timescale 1ns/1ps

`include "kf_consts.svh"

module kf_state_predict (
	input  logic                   clk,
	input  logic                   aresetn,
	kf_step_if.dp                  step,
	output kf_pkg::kf_fix_t        o_x_next [0:`KF_NM-1],
	output logic [`KF_DISP_W-1:0]  o_pos_x,
	output logic [`KF_DISP_W-1:0]  o_pos_y
);

	import kf_pkg::*;

	localparam kf_fix_t ONE   = `KF_ONE;
	localparam kf_fix_t TSTEP = `KF_TSTEP;

	kf_fix_t x_curr [0:`KF_NS-1];
	kf_fix_t x_next [0:`KF_NS-1];
	kf_fix_t x_pred [0:`KF_NS-1];

	// F is identity with the time step coupling velocity into position
	always_comb begin
		x_pred[0] = fix_add(x_curr[0], fix_mul(TSTEP, x_curr[2]));
		x_pred[1] = fix_add(x_curr[1], fix_mul(TSTEP, x_curr[3]));
		x_pred[2] = x_curr[2];
		x_pred[3] = x_curr[3];
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < `KF_NS; i++) begin
				x_curr[i] <= ONE;
				x_next[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `KF_NS; i++) begin
				if (step.clear_all) begin
					x_curr[i] <= ONE;
				end else if (step.ld_update) begin
					x_curr[i] <= x_next[i];
				end
				if (step.clear_tmp) begin
					x_next[i] <= '0;
				end else if (step.ld_pred1) begin
					x_next[i] <= x_pred[i];
				end
			end
		end
	end

	assign o_x_next[0] = x_next[0];
	assign o_x_next[1] = x_next[1];

	// Integer part of the committed position, low bits only
	assign o_pos_x = x_curr[0].f.int_part[`KF_DISP_W-1:0];
	assign o_pos_y = x_curr[1].f.int_part[`KF_DISP_W-1:0];

endmodule

/* kf_cov_predict.sv */
// Kalman covariance prediction
// Computes P_next = F*P*F' + Q in two registered steps and commits it on update.

`timescale 1ns/1ps

`include "kf_consts.svh"

module kf_cov_predict (
	input  logic             clk,
	input  logic             aresetn,
	kf_step_if.dp            step,
	output kf_pkg::kf_fix_t  o_p_meas [0:`KF_NM-1][0:`KF_NM-1]
);

	import kf_pkg::*;

	localparam kf_fix_t ONE   = `KF_ONE;
	localparam kf_fix_t TSTEP = `KF_TSTEP;
	localparam kf_fix_t ZERO  = '0;

	kf_fix_t p_curr  [0:`KF_NS-1][0:`KF_NS-1];
	kf_fix_t fp_reg  [0:`KF_NS-1][0:`KF_NS-1];
	kf_fix_t p_next  [0:`KF_NS-1][0:`KF_NS-1];
	kf_fix_t fp_sum  [0:`KF_NS-1][0:`KF_NS-1];
	kf_fix_t fpf_sum [0:`KF_NS-1][0:`KF_NS-1];

	// Transition matrix element
	function automatic kf_fix_t f_elem(input int r, input int c);
		if (r == c) begin
			return ONE;
		end else if ((r == 0 && c == 2) || (r == 1 && c == 3)) begin
			return TSTEP;
		end
		return ZERO;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Products and balanced adder trees
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		kf_fix_t m [0:`KF_NS-1];
		kf_fix_t n [0:`KF_NS-1];
		for (int i = 0; i < `KF_NS; i++) begin
			for (int j = 0; j < `KF_NS; j++) begin
				for (int k = 0; k < `KF_NS; k++) begin
					m[k] = fix_mul(f_elem(i, k), p_curr[k][j]);
					// F transposed, indices swapped
					n[k] = fix_mul(fp_reg[i][k], f_elem(j, k));
				end
				fp_sum[i][j] = fix_add(fix_add(m[0], m[1]), fix_add(m[2], m[3]));
				fpf_sum[i][j] = fix_add(fix_add(fix_add(n[0], n[1]), fix_add(n[2], n[3])),
					(i == j) ? ONE : ZERO);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Covariance registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < `KF_NS; i++) begin
				for (int j = 0; j < `KF_NS; j++) begin
					p_curr[i][j] <= (i == j) ? ONE : ZERO;
					fp_reg[i][j] <= '0;
					p_next[i][j] <= '0;
				end
			end
		end else begin
			for (int i = 0; i < `KF_NS; i++) begin
				for (int j = 0; j < `KF_NS; j++) begin
					if (step.clear_all) begin
						p_curr[i][j] <= (i == j) ? ONE : ZERO;
					end else if (step.ld_update) begin
						p_curr[i][j] <= p_next[i][j];
					end
					if (step.clear_tmp) begin
						fp_reg[i][j] <= '0;
						p_next[i][j] <= '0;
					end else begin
						if (step.ld_pred1) begin
							fp_reg[i][j] <= fp_sum[i][j];
						end
						if (step.ld_pred2) begin
							p_next[i][j] <= fpf_sum[i][j];
						end
					end
				end
			end
		end
	end

	// Position block of the predicted covariance
	always_comb begin
		for (int i = 0; i < `KF_NM; i++) begin
			for (int j = 0; j < `KF_NM; j++) begin
				o_p_meas[i][j] = p_next[i][j];
			end
		end
	end

endmodule

/* kf_innovation.sv */
// Kalman innovation
// Captures the measurement, forms the innovation and the residual covariance S,
// and registers the determinant of S.

`timescale 1ns/1ps

`include "kf_consts.svh"

module kf_innovation (
	input  logic                   clk,
	input  logic                   aresetn,
	kf_step_if.dp                  step,
	input  logic [`KF_DISP_W-1:0]  i_z_x,
	input  logic [`KF_DISP_W-1:0]  i_z_y,
	input  kf_pkg::kf_fix_t        i_x_next [0:`KF_NM-1],
	input  kf_pkg::kf_fix_t        i_p_meas [0:`KF_NM-1][0:`KF_NM-1],
	output kf_pkg::kf_fix_t        o_innov_x,
	output kf_pkg::kf_fix_t        o_innov_y,
	output kf_pkg::kf_fix_t        o_s_det
);

	import kf_pkg::*;

	localparam kf_fix_t RDIAG = `KF_RDIAG;
	localparam kf_fix_t ZERO  = '0;

	kf_fix_t z_vec [0:`KF_NM-1];
	kf_fix_t y_vec [0:`KF_NM-1];
	kf_fix_t s_mat [0:`KF_NM-1][0:`KF_NM-1];
	kf_fix_t y_sub [0:`KF_NM-1];
	kf_fix_t s_add [0:`KF_NM-1][0:`KF_NM-1];
	kf_fix_t det_a;
	kf_fix_t det_b;
	kf_fix_t det_val;

	always_comb begin
		for (int i = 0; i < `KF_NM; i++) begin
			y_sub[i] = fix_sub(z_vec[i], i_x_next[i]);
			for (int j = 0; j < `KF_NM; j++) begin
				// R is diagonal
				s_add[i][j] = fix_add(i_p_meas[i][j], (i == j) ? RDIAG : ZERO);
			end
		end
	end

	// 2x2 determinant of the registered S
	assign det_a   = fix_mul(s_mat[0][0], s_mat[1][1]);
	assign det_b   = fix_mul(s_mat[0][1], s_mat[1][0]);
	assign det_val = fix_sub(det_a, det_b);

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < `KF_NM; i++) begin
				z_vec[i] <= '0;
				y_vec[i] <= '0;
				for (int j = 0; j < `KF_NM; j++) begin
					s_mat[i][j] <= '0;
				end
			end
			o_s_det <= '0;
		end else begin
			// Measurement enters as a positive integer word
			if (step.accept) begin
				z_vec[0] <= {1'b0, {(`KF_I-`KF_DISP_W){1'b0}}, i_z_x, {`KF_F{1'b0}}};
				z_vec[1] <= {1'b0, {(`KF_I-`KF_DISP_W){1'b0}}, i_z_y, {`KF_F{1'b0}}};
			end
			if (step.ld_innov) begin
				y_vec <= y_sub;
				s_mat <= s_add;
			end
			if (step.ld_det) begin
				o_s_det <= det_val;
			end
		end
	end

	assign o_innov_x = y_vec[0];
	assign o_innov_y = y_vec[1];

endmodule

/* kf_top.sv */
// Kalman tracker top level
// Constant-velocity tracker with two position measurements; exposes the
// committed position, the innovation and the determinant of S.

`timescale 1ns/1ps

`include "kf_consts.svh"

module kf_top (
	input  logic                   clk,
	input  logic                   aresetn,
	input  logic [`KF_DISP_W-1:0]  i_z_x,
	input  logic [`KF_DISP_W-1:0]  i_z_y,
	input  logic                   i_valid,
	output logic                   o_ready,
	output logic [`KF_DISP_W-1:0]  o_pos_x,
	output logic [`KF_DISP_W-1:0]  o_pos_y,
	output kf_pkg::kf_fix_t        o_innov_x,
	output kf_pkg::kf_fix_t        o_innov_y,
	output kf_pkg::kf_fix_t        o_s_det
);

	import kf_pkg::*;

	kf_fix_t x_next [0:`KF_NM-1];
	kf_fix_t p_meas [0:`KF_NM-1][0:`KF_NM-1];

	kf_step_if step_bus ();

	kf_sequencer u_seq (
		.clk     (clk),
		.aresetn (aresetn),
		.i_valid (i_valid),
		.o_ready (o_ready),
		.step    (step_bus.seq)
	);

	kf_state_predict u_state (
		.clk      (clk),
		.aresetn  (aresetn),
		.step     (step_bus.dp),
		.o_x_next (x_next),
		.o_pos_x  (o_pos_x),
		.o_pos_y  (o_pos_y)
	);

	kf_cov_predict u_cov (
		.clk      (clk),
		.aresetn  (aresetn),
		.step     (step_bus.dp),
		.o_p_meas (p_meas)
	);

	kf_innovation u_innov (
		.clk       (clk),
		.aresetn   (aresetn),
		.step      (step_bus.dp),
		.i_z_x     (i_z_x),
		.i_z_y     (i_z_y),
		.i_x_next  (x_next),
		.i_p_meas  (p_meas),
		.o_innov_x (o_innov_x),
		.o_innov_y (o_innov_y),
		.o_s_det   (o_s_det)
	);

endmodule

/* kf_tb.sv */
// Kalman tracker testbench
// Replays measurement pairs from the data file and checks position, innovation
// and the determinant of S after every filter iteration.

`timescale 1ns/1ps

`include "kf_consts.svh"

module kf_tb;

	import kf_pkg::*;

	localparam int BUSY_CYCLES = 5;
	localparam int BUSY_LIMIT  = 20;

	logic                   clk;
	logic                   aresetn;
	logic [`KF_DISP_W-1:0]  i_z_x;
	logic [`KF_DISP_W-1:0]  i_z_y;
	logic                   i_valid;
	logic                   o_ready;
	logic [`KF_DISP_W-1:0]  o_pos_x;
	logic [`KF_DISP_W-1:0]  o_pos_y;
	kf_fix_t                o_innov_x;
	kf_fix_t                o_innov_y;
	kf_fix_t                o_s_det;

	kf_top DUT (
		.clk       (clk),
		.aresetn   (aresetn),
		.i_z_x     (i_z_x),
		.i_z_y     (i_z_y),
		.i_valid   (i_valid),
		.o_ready   (o_ready),
		.o_pos_x   (o_pos_x),
		.o_pos_y   (o_pos_y),
		.o_innov_x (o_innov_x),
		.o_innov_y (o_innov_y),
		.o_s_det   (o_s_det)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_pos(input string name, input logic [`KF_DISP_W-1:0] got,
		input logic [`KF_DISP_W-1:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_fix(input string name, input kf_fix_t got, input kf_fix_t exp);
		if (got.raw !== exp.raw) begin
			stop_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got.raw, exp.raw));
		end
	endtask

	// Polls on falling edges until ready is seen or the limit runs out
	task automatic wait_for_ready(input int limit);
		int n;
		n = 0;
		while (!o_ready) begin
			if (n >= limit) begin
				stop_run("Timeout: the tracker never became ready");
			end
			@(negedge clk);
			n++;
		end
	endtask

	initial begin
		int                    fd;
		int                    idle;
		int                    busy;
		int                    steps;
		string                 line;
		logic [31:0]           junk;
		logic [`KF_DISP_W-1:0] zx;
		logic [`KF_DISP_W-1:0] zy;
		logic [`KF_DISP_W-1:0] px;
		logic [`KF_DISP_W-1:0] py;
		logic [`KF_W-1:0]      ix;
		logic [`KF_W-1:0]      iy;
		logic [`KF_W-1:0]      det;

		steps   = 0;
		aresetn = 1'b0;
		i_valid = 1'b0;
		i_z_x   = '0;
		i_z_y   = '0;
		void'($urandom(52));

		repeat (8) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;
		// INIT lasts until the first rising edge after release
		if (o_ready) begin
			stop_run("Ready was high during the INIT cycle");
		end
		wait_for_ready(2);
		check_pos("o_pos_x", o_pos_x, 11'h001);
		check_pos("o_pos_y", o_pos_y, 11'h001);

		fd = $fopen("kf_testdata.txt", "r");
		if (fd == 0) begin
			stop_run("Could not open the data file kf_testdata.txt");
		end

		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0) begin
				break;
			end
			if (line.len() < 3 || line.substr(0, 1) == "//") begin
				continue;
			end
			if ($sscanf(line, "%h %h %h %h %h %h %h", zx, zy, px, py, ix, iy, det) != 7) begin
				stop_run("A line of the data file could not be parsed");
			end

			idle = $urandom_range(7, 0);
			repeat (idle) @(negedge clk);
			wait_for_ready(BUSY_LIMIT);
			i_z_x   = zx;
			i_z_y   = zy;
			i_valid = 1'b1;
			@(negedge clk);

			// Valid stays high with junk values that the busy tracker must ignore
			busy = 0;
			while (!o_ready) begin
				busy++;
				if (busy > BUSY_LIMIT) begin
					stop_run("Timeout: ready did not return after a measurement");
				end
				junk  = $urandom();
				i_z_x = junk[`KF_DISP_W-1:0];
				junk  = $urandom();
				i_z_y = junk[`KF_DISP_W-1:0];
				@(negedge clk);
			end
			i_valid = 1'b0;
			if (busy != BUSY_CYCLES) begin
				stop_run($sformatf("Ready was low for %0d cycles instead of %0d",
					busy, BUSY_CYCLES));
			end

			check_pos("o_pos_x", o_pos_x, px);
			check_pos("o_pos_y", o_pos_y, py);
			check_fix("o_innov_x", o_innov_x, ix);
			check_fix("o_innov_y", o_innov_y, iy);
			check_fix("o_s_det", o_s_det, det);
			steps++;
		end
		$fclose(fd);

		if (steps == 0) begin
			stop_run("The data file held no measurements");
		end

		$display("Test passed");
		$finish;
	end

endmodule

/* kf_testdata.txt */
// One measurement per line, all values in hex
// z_x z_y pos_x pos_y innov_x innov_y s_det
005 000 001 001 0001FC00 80008400 28F2FA80
00A 001 001 001 00047800 80000800 2CE165C0
001 003 001 001 80000C00 0000F400 30D5BA06
100 002 001 001 007F7000 00007000 34D1F19C
000 7FF 001 001 80009400 03FEEC00 38D808DE
002 001 001 001 00006800 80001800 3CE9FE42
001 001 001 001 80001C00 80001C00 4109D264
020 010 001 001 000F6000 00076000 45398814

/* src.f */
+incdir+.
kf_pkg.sv
kf_step_if.sv
kf_sequencer.sv
kf_state_predict.sv
kf_cov_predict.sv
kf_innovation.sv
kf_top.sv
kf_tb.sv
